// ==== logic/sv32_pkg.sv ====
// Sv32 address widths, page table entry layout and privilege levels
// shared by the data-side translation logic

package sv32_pkg;

    // ------------------------------------------------------------
    // address geometry
    // ------------------------------------------------------------
    // virtual address width
    localparam int unsigned VLEN = 32;
    // physical address width, Sv32 allows 34 bits
    localparam int unsigned PLEN = 34;
    // physical page number width
    localparam int unsigned PPNW = 22;
    // virtual page number width, vpn1 and vpn0 of 10 bits each
    localparam int unsigned VPNW = 20;
    // 4 KiB page offset
    localparam int unsigned PAGE_OFFSET_W = 12;

    // ------------------------------------------------------------
    // page table entry
    // ------------------------------------------------------------
    // leaf entry as stored in the TLB, msb first
    typedef struct packed {
        logic [PPNW-1:0] ppn;
        // reserved for software
        logic [1:0]      rsw;
        logic            d;
        logic            a;
        logic            g;
        logic            u;
        logic            x;
        logic            w;
        logic            r;
        logic            v;
    } pte_sv32_t;

    // effective privilege of the load/store
    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'b00,
        PRIV_LVL_S = 2'b01,
        PRIV_LVL_M = 2'b11
    } priv_lvl_t;

endpackage

// ==== logic/mmu_pkg.sv ====
// exception causes, exception record, load/store request bundle
// and the TLB refill struct

package mmu_pkg;

    // ------------------------------------------------------------
    // exceptions
    // ------------------------------------------------------------
    // plain 32-bit code, misaligned causes from upstream travel as is
    typedef logic [31:0] exc_cause_t;

    localparam exc_cause_t LOAD_PAGE_FAULT  = 32'd13;
    localparam exc_cause_t STORE_PAGE_FAULT = 32'd15;

    // cause, faulting value and valid flag
    typedef struct packed {
        exc_cause_t  cause;
        logic [31:0] tval;
        logic        valid;
    } exception_t;

    // ------------------------------------------------------------
    // load/store request
    // ------------------------------------------------------------
    typedef struct packed {
        logic                        req;
        logic [sv32_pkg::VLEN-1:0]   vaddr;
        logic                        is_store;
        // misaligned exception raised before translation
        exception_t                  misaligned;
    } lsu_req_t;

    // ------------------------------------------------------------
    // TLB refill
    // ------------------------------------------------------------
    // asid width carried by the update port
    localparam int unsigned TLB_ASID_W = 1;

    typedef struct packed {
        logic                        valid;
        // megapage, only vpn[19:10] is significant
        logic                        is_4m;
        logic [sv32_pkg::VPNW-1:0]   vpn;
        logic [TLB_ASID_W-1:0]       asid;
        sv32_pkg::pte_sv32_t         content;
    } tlb_update_t;

endpackage

// ==== logic/dtlb_sv32.sv ====
// fully associative ASID-tagged data TLB for Sv32
// round-robin refill and a full flush
`timescale 1ns/1ps

module dtlb_sv32 #(
    parameter int unsigned TLB_ENTRIES = 4,
    parameter int unsigned ASID_WIDTH  = 1
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    // lookup port
    input  logic                          lu_access_i,
    input  logic [sv32_pkg::VLEN-1:0]     lu_vaddr_i,
    input  logic [ASID_WIDTH-1:0]         lu_asid_i,
    // refill port
    input  mmu_pkg::tlb_update_t          update_i,
    // lookup answer in the same cycle
    output logic                          lu_hit_o,
    output logic                          lu_is_4m_o,
    output sv32_pkg::pte_sv32_t           lu_content_o
);

    // pointer width with a floor of one bit
    localparam int unsigned IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    // per-entry tag
    typedef struct packed {
        logic [ASID_WIDTH-1:0] asid;
        logic [9:0]            vpn1;
        logic [9:0]            vpn0;
        logic                  is_4m;
    } tag_t;

    logic [TLB_ENTRIES-1:0] valid_q;
    tag_t                   tag_q     [TLB_ENTRIES];
    sv32_pkg::pte_sv32_t    content_q [TLB_ENTRIES];
    logic [IDX_W-1:0]       rr_q;
    logic [TLB_ENTRIES-1:0] hit;
    logic                   do_update;

    // a flush wins over a refill in the same cycle
    assign do_update = update_i.valid & ~flush_i;

    // ------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------
    always_comb begin
        hit          = '0;
        lu_is_4m_o   = 1'b0;
        lu_content_o = '0;
        for (int unsigned i = 0; i < TLB_ENTRIES; i++) begin
            // asid match or global page
            if (valid_q[i] && ((tag_q[i].asid == lu_asid_i) || content_q[i].g) &&
                (tag_q[i].vpn1 == lu_vaddr_i[31:22]) &&
                // megapage ignores vpn0
                (tag_q[i].is_4m || (tag_q[i].vpn0 == lu_vaddr_i[21:12]))) begin
                hit[i]       = 1'b1;
                lu_is_4m_o   = tag_q[i].is_4m;
                lu_content_o = content_q[i];
            end
        end
    end

    assign lu_hit_o = lu_access_i & (|hit);

    // ------------------------------------------------------------
    // valid bits and replacement pointer
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[rr_q] <= 1'b1;
            // wrap after the last entry
            if (rr_q == IDX_W'(TLB_ENTRIES - 1)) begin
                rr_q <= '0;
            end else begin
                rr_q <= rr_q + IDX_W'(1);
            end
        end
    end

    // tag and pte storage
    always_ff @(posedge clk_i) begin
        if (do_update) begin
            tag_q[rr_q].asid    <= ASID_WIDTH'(update_i.asid);
            tag_q[rr_q].vpn1    <= update_i.vpn[19:10];
            tag_q[rr_q].vpn0    <= update_i.vpn[9:0];
            tag_q[rr_q].is_4m   <= update_i.is_4m;
            content_q[rr_q]     <= update_i.content;
        end
    end

    // refills never create overlapping mappings for one asid
    a_single_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(hit))
        else $error("dtlb: more than one entry hit");

endmodule

// ==== logic/lsu_req_stage.sv ====
// pipeline register between TLB lookup and fault checking
`timescale 1ns/1ps

module lsu_req_stage (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // request and TLB answer of cycle 0
    input  mmu_pkg::lsu_req_t     lsu_req_i,
    input  logic                  dtlb_hit_i,
    input  logic                  dtlb_is_4m_i,
    input  sv32_pkg::pte_sv32_t   dtlb_content_i,
    // same, one cycle later
    output mmu_pkg::lsu_req_t     req_q_o,
    output logic                  dtlb_hit_q_o,
    output logic                  dtlb_is_4m_q_o,
    output sv32_pkg::pte_sv32_t   dtlb_content_q_o
);

    mmu_pkg::lsu_req_t req_d;

    // drop a stray misaligned flag when no request is present
    always_comb begin
        req_d                  = lsu_req_i;
        req_d.misaligned.valid = lsu_req_i.misaligned.valid & lsu_req_i.req;
    end

    // request bundle and hit info
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q_o        <= '0;
            dtlb_hit_q_o   <= 1'b0;
            dtlb_is_4m_q_o <= 1'b0;
        end else begin
            req_q_o        <= req_d;
            dtlb_hit_q_o   <= dtlb_hit_i;
            dtlb_is_4m_q_o <= dtlb_is_4m_i;
        end
    end

    // pte payload, only read behind the registered hit
    always_ff @(posedge clk_i) begin
        dtlb_content_q_o <= dtlb_content_i;
    end

endmodule

// ==== logic/dtlb_fault_check.sv ====
// physical address forming, valid strobe and page-fault checks
// for the second cycle of a load/store translation
`timescale 1ns/1ps

module dtlb_fault_check (
    // registered request and TLB answer
    input  mmu_pkg::lsu_req_t          req_q_i,
    input  logic                       dtlb_hit_q_i,
    input  logic                       dtlb_is_4m_q_i,
    input  sv32_pkg::pte_sv32_t        dtlb_content_q_i,
    // csr state
    input  logic                       en_ld_st_translation_i,
    input  sv32_pkg::priv_lvl_t        ld_st_priv_lvl_i,
    input  logic                       sum_i,
    // result
    output logic                       lsu_valid_o,
    output logic [sv32_pkg::PLEN-1:0]  lsu_paddr_o,
    output mmu_pkg::exception_t        lsu_exception_o
);

    localparam int unsigned OFS = sv32_pkg::PAGE_OFFSET_W;

    logic                       daccess_err;
    logic                       xlat_ok;
    logic [sv32_pkg::PLEN-1:0]  paddr_xlat;

    // ------------------------------------------------------------
    // privilege check
    // ------------------------------------------------------------
    // S mode touching a user page needs SUM, U mode needs a user page
    assign daccess_err =
        ((ld_st_priv_lvl_i == sv32_pkg::PRIV_LVL_S) && !sum_i && dtlb_content_q_i.u) ||
        ((ld_st_priv_lvl_i == sv32_pkg::PRIV_LVL_U) && !dtlb_content_q_i.u);

    // translated request that found its entry
    assign xlat_ok = req_q_i.req & dtlb_hit_q_i;

    // ppn and offset, megapage keeps vaddr bits 21:12
    always_comb begin
        paddr_xlat = {dtlb_content_q_i.ppn, req_q_i.vaddr[OFS-1:0]};
        if (dtlb_is_4m_q_i) begin
            paddr_xlat[21:12] = req_q_i.vaddr[21:12];
        end
    end

    // ------------------------------------------------------------
    // result forming
    // ------------------------------------------------------------
    always_comb begin
        // bare mode or misaligned, pass the address through
        lsu_paddr_o     = {{(sv32_pkg::PLEN - sv32_pkg::VLEN){1'b0}}, req_q_i.vaddr};
        lsu_valid_o     = req_q_i.req;
        lsu_exception_o = req_q_i.misaligned;

        if (en_ld_st_translation_i && !req_q_i.misaligned.valid) begin
            lsu_paddr_o     = paddr_xlat;
            // a miss gives no result at all
            lsu_valid_o     = xlat_ok;
            lsu_exception_o = '0;
            if (xlat_ok) begin
                if (req_q_i.is_store) begin
                    // stores need w and d set as well
                    if (daccess_err || !dtlb_content_q_i.w || !dtlb_content_q_i.d) begin
                        lsu_exception_o.cause = mmu_pkg::STORE_PAGE_FAULT;
                        lsu_exception_o.tval  = req_q_i.vaddr;
                        lsu_exception_o.valid = 1'b1;
                    end
                end else if (daccess_err) begin
                    lsu_exception_o.cause = mmu_pkg::LOAD_PAGE_FAULT;
                    lsu_exception_o.tval  = req_q_i.vaddr;
                    lsu_exception_o.valid = 1'b1;
                end
            end
        end
    end

    // relies on the request stage masking misaligned with req
    a_exc_needs_valid: assert final (!lsu_exception_o.valid || lsu_valid_o)
        else $error("dmmu: exception without valid result");

endmodule

// ==== logic/dmmu_sv32_top.sv ====
// data-side Sv32 translation unit, request capture, TLB and fault stage
`timescale 1ns/1ps

module dmmu_sv32_top #(
    parameter int unsigned TLB_ENTRIES = 4,
    parameter int unsigned ASID_WIDTH  = 1
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    // load/store request
    input  mmu_pkg::lsu_req_t             lsu_req_i,
    input  logic                          en_ld_st_translation_i,
    input  sv32_pkg::priv_lvl_t           ld_st_priv_lvl_i,
    input  logic                          sum_i,
    input  logic [ASID_WIDTH-1:0]         asid_i,
    // TLB maintenance
    input  logic                          flush_tlb_i,
    input  mmu_pkg::tlb_update_t          update_i,
    // cycle 0
    output logic                          lsu_dtlb_hit_o,
    output logic [sv32_pkg::PPNW-1:0]     lsu_dtlb_ppn_o,
    // cycle 1
    output logic                          lsu_valid_o,
    output logic [sv32_pkg::PLEN-1:0]     lsu_paddr_o,
    output mmu_pkg::exception_t           lsu_exception_o,
    output logic                          dtlb_miss_o
);

    logic                 dtlb_hit;
    logic                 dtlb_is_4m;
    sv32_pkg::pte_sv32_t  dtlb_content;
    mmu_pkg::lsu_req_t    req_q;
    logic                 dtlb_hit_q;
    logic                 dtlb_is_4m_q;
    sv32_pkg::pte_sv32_t  dtlb_content_q;

    // ------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------
    dtlb_sv32 #(
        .TLB_ENTRIES ( TLB_ENTRIES ),
        .ASID_WIDTH  ( ASID_WIDTH  )
    ) u_dtlb (
        .clk_i        ( clk_i           ),
        .rst_ni       ( rst_ni          ),
        .flush_i      ( flush_tlb_i     ),
        .lu_access_i  ( lsu_req_i.req   ),
        .lu_vaddr_i   ( lsu_req_i.vaddr ),
        .lu_asid_i    ( asid_i          ),
        .update_i     ( update_i        ),
        .lu_hit_o     ( dtlb_hit        ),
        .lu_is_4m_o   ( dtlb_is_4m      ),
        .lu_content_o ( dtlb_content    )
    );

    // bare mode always counts as a hit
    assign lsu_dtlb_hit_o = en_ld_st_translation_i ? dtlb_hit : 1'b1;

    // megapage takes vpn0 from the address, bare mode the zero-extended vpn
    assign lsu_dtlb_ppn_o = !en_ld_st_translation_i ?
                                sv32_pkg::PPNW'(lsu_req_i.vaddr[31:12]) :
                            dtlb_is_4m ? {dtlb_content.ppn[21:10], lsu_req_i.vaddr[21:12]} :
                                dtlb_content.ppn;

    assign dtlb_miss_o = en_ld_st_translation_i & lsu_req_i.req & ~dtlb_hit;

    // ------------------------------------------------------------
    // second cycle
    // ------------------------------------------------------------
    lsu_req_stage u_req_stage (
        .clk_i            ( clk_i          ),
        .rst_ni           ( rst_ni         ),
        .lsu_req_i        ( lsu_req_i      ),
        .dtlb_hit_i       ( dtlb_hit       ),
        .dtlb_is_4m_i     ( dtlb_is_4m     ),
        .dtlb_content_i   ( dtlb_content   ),
        .req_q_o          ( req_q          ),
        .dtlb_hit_q_o     ( dtlb_hit_q     ),
        .dtlb_is_4m_q_o   ( dtlb_is_4m_q   ),
        .dtlb_content_q_o ( dtlb_content_q )
    );

    dtlb_fault_check u_fault_check (
        .req_q_i                ( req_q                  ),
        .dtlb_hit_q_i           ( dtlb_hit_q             ),
        .dtlb_is_4m_q_i         ( dtlb_is_4m_q           ),
        .dtlb_content_q_i       ( dtlb_content_q         ),
        .en_ld_st_translation_i ( en_ld_st_translation_i ),
        .ld_st_priv_lvl_i       ( ld_st_priv_lvl_i       ),
        .sum_i                  ( sum_i                  ),
        .lsu_valid_o            ( lsu_valid_o            ),
        .lsu_paddr_o            ( lsu_paddr_o            ),
        .lsu_exception_o        ( lsu_exception_o        )
    );

    // the refill port carries a fixed-width asid, the lookup side must agree
    a_asid_width: assert property (@(posedge clk_i) ASID_WIDTH == mmu_pkg::TLB_ASID_W)
        else $error("dmmu: ASID_WIDTH differs from the update port width");

endmodule

// ==== dv/dmmu_checker.sv ====
// result checker for the DMMU testbench
// compares lookup outputs in cycle 0 and translation results in cycle 1
`timescale 1ns/1ps

module dmmu_checker #(
    parameter int unsigned NAME_W = 128
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    // expectations, present together with the request
    input  logic                         chk_i,
    input  logic [NAME_W-1:0]            name_i,
    input  logic                         exp_hit_i,
    input  logic [sv32_pkg::PPNW-1:0]    exp_ppn_i,
    input  logic                         exp_miss_i,
    input  logic                         exp_valid_i,
    input  logic [sv32_pkg::PLEN-1:0]    exp_paddr_i,
    input  mmu_pkg::exception_t          exp_exc_i,
    // observed DUT outputs
    input  logic                         dut_hit_i,
    input  logic [sv32_pkg::PPNW-1:0]    dut_ppn_i,
    input  logic                         dut_miss_i,
    input  logic                         dut_valid_i,
    input  logic [sv32_pkg::PLEN-1:0]    dut_paddr_i,
    input  mmu_pkg::exception_t          dut_exc_i,
    // running totals
    output int unsigned                  test_cnt_o,
    output int unsigned                  err_cnt_o
);

    // request now sitting in the output stage
    logic                       pend;
    logic [NAME_W-1:0]          pend_name;
    logic                       pend_valid;
    logic [sv32_pkg::PLEN-1:0]  pend_paddr;
    mmu_pkg::exception_t        pend_exc;
    // mismatches of the test in progress
    int unsigned                test_err;

    task automatic compare_field(input logic [NAME_W-1:0] name, input string field,
                                 input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            $display("mismatch %0s %0s: expected %0h actual %0h", name, field, expected, actual);
            test_err++;
        end
    endtask

    task automatic close_test(input logic [NAME_W-1:0] name);
        if (test_err == 0) begin
            $display("test %0s: ok", name);
        end else begin
            $display("test %0s: %0d mismatches", name, test_err);
        end
        test_cnt_o++;
        err_cnt_o += test_err;
        test_err = 0;
    endtask

    // ------------------------------------------------------------
    // sampling on the rising edge, before inputs change
    // ------------------------------------------------------------
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend       = 1'b0;
            test_err   = 0;
            test_cnt_o = 0;
            err_cnt_o  = 0;
        end else begin
            // second cycle of the previous request
            if (pend) begin
                compare_field(pend_name, "valid", 64'(pend_valid), 64'(dut_valid_i));
                // address only means something with valid high
                if (pend_valid) begin
                    compare_field(pend_name, "paddr", 64'(pend_paddr), 64'(dut_paddr_i));
                end
                compare_field(pend_name, "exc_valid", 64'(pend_exc.valid),
                              64'(dut_exc_i.valid));
                if (pend_exc.valid) begin
                    compare_field(pend_name, "cause", 64'(pend_exc.cause), 64'(dut_exc_i.cause));
                    compare_field(pend_name, "tval", 64'(pend_exc.tval), 64'(dut_exc_i.tval));
                end
                close_test(pend_name);
            end
            pend = 1'b0;
            // lookup of the request seen in the last cycle
            if (chk_i) begin
                compare_field(name_i, "hit", 64'(exp_hit_i), 64'(dut_hit_i));
                compare_field(name_i, "miss", 64'(exp_miss_i), 64'(dut_miss_i));
                // ppn is a don't care on a miss
                if (exp_hit_i) begin
                    compare_field(name_i, "ppn", 64'(exp_ppn_i), 64'(dut_ppn_i));
                end
                pend       = 1'b1;
                pend_name  = name_i;
                pend_valid = exp_valid_i;
                pend_paddr = exp_paddr_i;
                pend_exc   = exp_exc_i;
            end
        end
    end

endmodule

// ==== dv/tb_dmmu.sv ====
// testbench top for the data-side Sv32 translation unit
// clock, reset, stimulus from file, watchdog and final verdict
`timescale 1ns/1ps

module tb_dmmu;

    localparam int unsigned TLB_ENTRIES     = 4;
    localparam int unsigned ASID_WIDTH      = 1;
    localparam int unsigned NAME_W          = 8 * 16;
    localparam int unsigned RESET_CYCLES    = 3;
    // watchdog budget for one stimulus line
    localparam int unsigned CYCLES_PER_LINE = 10;
    localparam string       STIM_FILE       = "dv/dmmu_stimulus.txt";

    logic                        clk;
    logic                        rst_n;
    mmu_pkg::lsu_req_t           lsu_req;
    logic                        en_xlat;
    sv32_pkg::priv_lvl_t         priv_lvl;
    logic                        sum_on;
    logic [ASID_WIDTH-1:0]       asid;
    logic                        flush_tlb;
    mmu_pkg::tlb_update_t        update;
    logic                        dtlb_hit;
    logic [sv32_pkg::PPNW-1:0]   dtlb_ppn;
    logic                        lsu_valid;
    logic [sv32_pkg::PLEN-1:0]   lsu_paddr;
    mmu_pkg::exception_t         lsu_exc;
    logic                        dtlb_miss;

    // expected values for the checker
    logic                        chk;
    logic [NAME_W-1:0]           exp_name;
    logic                        exp_hit;
    logic [sv32_pkg::PPNW-1:0]   exp_ppn;
    logic                        exp_miss;
    logic                        exp_valid;
    logic [sv32_pkg::PLEN-1:0]   exp_paddr;
    mmu_pkg::exception_t         exp_exc;

    int unsigned                 test_cnt;
    int unsigned                 err_cnt;
    int unsigned                 file_err;
    int unsigned                 line_total;
    logic                        lines_known;

    dmmu_sv32_top #(
        .TLB_ENTRIES ( TLB_ENTRIES ),
        .ASID_WIDTH  ( ASID_WIDTH  )
    ) uut (
        .clk_i                  ( clk       ),
        .rst_ni                 ( rst_n     ),
        .lsu_req_i              ( lsu_req   ),
        .en_ld_st_translation_i ( en_xlat   ),
        .ld_st_priv_lvl_i       ( priv_lvl  ),
        .sum_i                  ( sum_on    ),
        .asid_i                 ( asid      ),
        .flush_tlb_i            ( flush_tlb ),
        .update_i               ( update    ),
        .lsu_dtlb_hit_o         ( dtlb_hit  ),
        .lsu_dtlb_ppn_o         ( dtlb_ppn  ),
        .lsu_valid_o            ( lsu_valid ),
        .lsu_paddr_o            ( lsu_paddr ),
        .lsu_exception_o        ( lsu_exc   ),
        .dtlb_miss_o            ( dtlb_miss )
    );

    dmmu_checker #(
        .NAME_W ( NAME_W )
    ) u_checker (
        .clk_i       ( clk       ),
        .rst_ni      ( rst_n     ),
        .chk_i       ( chk       ),
        .name_i      ( exp_name  ),
        .exp_hit_i   ( exp_hit   ),
        .exp_ppn_i   ( exp_ppn   ),
        .exp_miss_i  ( exp_miss  ),
        .exp_valid_i ( exp_valid ),
        .exp_paddr_i ( exp_paddr ),
        .exp_exc_i   ( exp_exc   ),
        .dut_hit_i   ( dtlb_hit  ),
        .dut_ppn_i   ( dtlb_ppn  ),
        .dut_miss_i  ( dtlb_miss ),
        .dut_valid_i ( lsu_valid ),
        .dut_paddr_i ( lsu_paddr ),
        .dut_exc_i   ( lsu_exc   ),
        .test_cnt_o  ( test_cnt  ),
        .err_cnt_o   ( err_cnt   )
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------
    // line handlers
    // ------------------------------------------------------------
    task automatic apply_update(input int fd);
        int                    cnt;
        logic [31:0]           f_4m;
        logic [31:0]           f_vpn;
        logic [31:0]           f_asid;
        logic [31:0]           f_pte;
        mmu_pkg::tlb_update_t  upd;
        cnt = $fscanf(fd, "%h %h %h %h", f_4m, f_vpn, f_asid, f_pte);
        if (cnt != 4) begin
            $display("error: an update line in the stimulus file is incomplete");
            file_err++;
        end else begin
            upd.valid   = 1'b1;
            upd.is_4m   = f_4m[0];
            upd.vpn     = f_vpn[sv32_pkg::VPNW-1:0];
            upd.asid    = f_asid[mmu_pkg::TLB_ASID_W-1:0];
            upd.content = sv32_pkg::pte_sv32_t'(f_pte);
            @(posedge clk);
            update <= upd;
            // written at this edge, usable from the next cycle on
            @(posedge clk);
            update.valid <= 1'b0;
        end
    endtask

    task automatic apply_flush();
        @(posedge clk);
        flush_tlb <= 1'b1;
        @(posedge clk);
        flush_tlb <= 1'b0;
    endtask

    task automatic apply_request(input int fd);
        int                    cnt;
        logic [NAME_W-1:0]     f_name;
        logic [31:0]           f_en;
        logic [31:0]           f_priv;
        logic [31:0]           f_sum;
        logic [31:0]           f_asid;
        logic [31:0]           f_vaddr;
        logic [31:0]           f_st;
        logic [31:0]           f_mv;
        logic [31:0]           f_mc;
        logic [31:0]           f_hit;
        logic [31:0]           f_ppn;
        logic [31:0]           f_miss;
        logic [31:0]           f_val;
        logic [63:0]           f_paddr;
        logic [31:0]           f_ev;
        logic [31:0]           f_ec;
        logic [31:0]           f_tval;
        mmu_pkg::lsu_req_t     req;
        mmu_pkg::exception_t   exc;
        cnt = $fscanf(fd, "%s %h %h %h %h %h %h %h %h", f_name, f_en, f_priv, f_sum,
                      f_asid, f_vaddr, f_st, f_mv, f_mc);
        cnt += $fscanf(fd, "%h %h %h %h %h %h %h %h", f_hit, f_ppn, f_miss, f_val,
                       f_paddr, f_ev, f_ec, f_tval);
        if (cnt != 17) begin
            $display("error: a request line in the stimulus file is incomplete");
            file_err++;
        end else begin
            req.req              = 1'b1;
            req.vaddr            = f_vaddr;
            req.is_store         = f_st[0];
            // upstream reports the faulting address itself
            req.misaligned.valid = f_mv[0];
            req.misaligned.cause = f_mc;
            req.misaligned.tval  = f_vaddr;
            exc.valid            = f_ev[0];
            exc.cause            = f_ec;
            exc.tval             = f_tval;
            @(posedge clk);
            lsu_req   <= req;
            en_xlat   <= f_en[0];
            priv_lvl  <= sv32_pkg::priv_lvl_t'(f_priv[1:0]);
            sum_on    <= f_sum[0];
            asid      <= f_asid[ASID_WIDTH-1:0];
            chk       <= 1'b1;
            exp_name  <= f_name;
            exp_hit   <= f_hit[0];
            exp_ppn   <= f_ppn[sv32_pkg::PPNW-1:0];
            exp_miss  <= f_miss[0];
            exp_valid <= f_val[0];
            exp_paddr <= f_paddr[sv32_pkg::PLEN-1:0];
            exp_exc   <= exc;
            // output stage reads the csr inputs live, so they stay one more cycle
            @(posedge clk);
            lsu_req.req <= 1'b0;
            chk         <= 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        int               fd;
        int               r;
        logic             done;
        logic [7:0]       kind;
        logic [8*128-1:0] rest;
        rst_n     <= 1'b0;
        lsu_req   <= '0;
        en_xlat   <= 1'b0;
        priv_lvl  <= sv32_pkg::PRIV_LVL_M;
        sum_on    <= 1'b0;
        asid      <= '0;
        flush_tlb <= 1'b0;
        update    <= '0;
        chk       <= 1'b0;
        exp_name  <= '0;
        exp_hit   <= 1'b0;
        exp_ppn   <= '0;
        exp_miss  <= 1'b0;
        exp_valid <= 1'b0;
        exp_paddr <= '0;
        exp_exc   <= '0;
        file_err    = 0;
        line_total  = 0;
        lines_known = 1'b0;
        done        = 1'b0;
        // first pass only sizes the watchdog
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("error: cannot open the stimulus file %s", STIM_FILE);
            file_err++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(rest, fd) != 0) begin
                    line_total++;
                end
            end
            $fclose(fd);
        end
        lines_known = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        if (file_err == 0) begin
            fd = $fopen(STIM_FILE, "r");
            while (!done) begin
                r = $fscanf(fd, "%s", kind);
                if (r != 1) begin
                    done = 1'b1;
                end else if (kind == "#") begin
                    r = $fgets(rest, fd);
                end else if (kind == "U") begin
                    apply_update(fd);
                end else if (kind == "F") begin
                    apply_flush();
                end else if (kind == "R") begin
                    apply_request(fd);
                end else begin
                    $display("error: unknown line kind %s in the stimulus file", kind);
                    file_err++;
                end
                if (file_err != 0) begin
                    done = 1'b1;
                end
            end
            $fclose(fd);
        end
        // last result shows one cycle after its request
        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("summary: %0d tests, %0d mismatches, %0d stimulus errors",
                 test_cnt, err_cnt, file_err);
        if ((err_cnt == 0) && (file_err == 0) && (test_cnt > 0)) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog sized from the stimulus line count
    initial begin
        wait (lines_known);
        repeat (RESET_CYCLES + line_total * CYCLES_PER_LINE) @(posedge clk);
        $display("timeout: stimulus did not finish within %0d cycles",
                 RESET_CYCLES + line_total * CYCLES_PER_LINE);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
logic/sv32_pkg.sv
logic/mmu_pkg.sv
logic/dtlb_sv32.sv
logic/lsu_req_stage.sv
logic/dtlb_fault_check.sv
logic/dmmu_sv32_top.sv
dv/dmmu_checker.sv
dv/tb_dmmu.sv

// ==== run.sh ====
#!/bin/sh
# build the DMMU testbench with Verilator, run it and look for the verdict in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module tb_dmmu -o sim_dmmu \
    > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/sim_dmmu > sim.log 2>&1
cat sim.log
grep -q "Testbench passed" sim.log && exit 0 || exit 1

// ==== dv/dmmu_stimulus.txt ====
# kinds: U is_4m vpn asid pte | F | R name en priv sum asid vaddr store mis_valid mis_cause
# R lines go on with expected hit ppn miss valid paddr exc_valid exc_cause exc_tval, all hex
R bare_ld       0 3 0 0 80001234 0 0 0  1 080001 0 1 080001234 0 0 0
R bare_mis      0 3 0 0 80001236 1 1 6  1 080001 0 1 080001236 1 6 80001236
U 0 12345 0 0AAF34C7
U 1 40000 0 0FF000D7
U 0 00ABC 0 00155443
U 0 00ABD 1 00155847
R pg4k_ld       1 1 0 0 12345678 0 0 0  1 2ABCD 0 1 02ABCD678 0 0 0
R pg4k_st       1 1 0 0 1234567C 1 0 0  1 2ABCD 0 1 02ABCD67C 0 0 0
R mega_ld_sum   1 1 1 0 40123ABC 0 0 0  1 3FD23 0 1 03FD23ABC 0 0 0
R mega_ld_nosum 1 1 0 0 40123ABC 0 0 0  1 3FD23 0 1 03FD23ABC 1 D 40123ABC
R mega_st_u     1 0 0 0 403FF004 1 0 0  1 3FFFF 0 1 03FFFF004 0 0 0
R kern_ld_u     1 0 0 0 12345010 0 0 0  1 2ABCD 0 1 02ABCD010 1 D 12345010
R ro_st         1 1 0 0 00ABC100 1 0 0  1 00555 0 1 000555100 1 F 00ABC100
R ro_ld         1 1 0 0 00ABC104 0 0 0  1 00555 0 1 000555104 0 0 0
R clean_st      1 1 0 1 00ABD200 1 0 0  1 00556 0 1 000556200 1 F 00ABD200
R asid_miss     1 1 0 0 00ABD200 0 0 0  0 0 1 0 0 0 0 0
R unmapped      1 1 0 0 7FFFF000 0 0 0  0 0 1 0 0 0 0 0
F
R flush_miss    1 1 0 0 12345678 0 0 0  0 0 1 0 0 0 0 0
U 0 12345 1 0048D0E7
R global_hit    1 1 0 0 12345ABC 0 0 0  1 01234 0 1 001234ABC 0 0 0
